// File: int_exec_unit.f
hdl/rv32_isa_pkg.sv
hdl/exec_unit_pkg.sv
hdl/issue_latch.sv
hdl/operand_select.sv
hdl/int_alu.sv
hdl/branch_resolve.sv
hdl/completion_queue.sv
hdl/int_exec_unit.sv
tb/int_exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the integer execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module int_exec_unit_tb -f int_exec_unit.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vint_exec_unit_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	echo "pass message not found"
	exit 1
fi

// File: tb/int_exec_unit_tb.sv
`timescale 1ns/1ps

module int_exec_unit_tb;

	localparam int queue_depth = 4;
	localparam int num_packets = 2000;
	localparam int timeout_cycles = 30 * num_packets;

	logic                          clock;
	logic                          reset;
	logic                          issue_valid;
	exec_unit_pkg::issue_packet_t  issue;
	logic                          result_ready;
	logic                          issue_ready;
	logic                          result_valid;
	exec_unit_pkg::result_packet_t result;

	integer seed;
	int     issue_kind;        // stimulus class of the offered packet
	logic   issue_fire = 1'b0; // issue transfer on the coming edge
	int     issued = 0;
	int     received = 0;
	int     in_flight = 0;
	int     max_in_flight = 0;
	int     cycles = 0;

	exec_unit_pkg::result_packet_t expected[$]; // scoreboard with the oldest entry first
	string                         expected_names[$];
	exec_unit_pkg::result_packet_t want;
	string                         name;

	int_exec_unit #(
		.queue_depth (queue_depth)
	) dut_i (
		.clock        (clock),
		.reset        (reset),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.result_ready (result_ready),
		.issue_ready  (issue_ready),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic fail_run(input string why);
		$display("ERROR %s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string test, input logic [31:0] want_value,
		input logic [31:0] got_value);
		if (got_value !== want_value) begin
			$display("ERROR %s expected %h actual %h", test, want_value, got_value);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// sign bits and extremes show up often
	function automatic rv32_isa_pkg::word_t edge_word();
		case (rand_below(8))
			0: return 32'h0000_0000;
			1: return 32'h0000_0001;
			2: return 32'hffff_ffff;
			3: return 32'h8000_0000;
			4: return 32'h7fff_ffff;
			5: return 32'h8000_0000 | $random(seed);
			default: return $random(seed);
		endcase
	endfunction

	function automatic string kind_name(input int kind);
		case (kind)
			0: return "reg_reg";
			1: return "multiply";
			2: return "immediate";
			default: return "branch";
		endcase
	endfunction

	function automatic exec_unit_pkg::issue_packet_t random_packet(input int kind);
		exec_unit_pkg::issue_packet_t p;
		p.pc            = $random(seed) & 32'hffff_fffc;
		p.npc           = p.pc + 32'd4;
		p.inst          = $random(seed);
		p.rs1_value     = $random(seed);
		p.rs2_value     = $random(seed); // shift amounts above 31 included
		p.opa_sel       = rv32_isa_pkg::opa_rs1;
		p.opb_sel       = rv32_isa_pkg::opb_rs2;
		p.alu_func      = rv32_isa_pkg::alu_func_e'(4'(rand_below(10))); // add .. sra
		p.cond_branch   = 1'b0;
		p.uncond_branch = 1'b0;
		p.dest_tag      = exec_unit_pkg::tag_t'(rand_below(64));
		if (kind == 1) begin
			p.rs1_value = edge_word();
			p.rs2_value = edge_word();
			p.alu_func  = rv32_isa_pkg::alu_func_e'(4'(10 + rand_below(4)));
		end else if (kind == 2) begin
			p.opa_sel  = rv32_isa_pkg::opa_sel_e'(2'(1 + rand_below(3)));
			p.opb_sel  = rv32_isa_pkg::opb_sel_e'(3'(1 + rand_below(5)));
			p.alu_func = rv32_isa_pkg::alu_func_e'(4'(rand_below(14)));
		end else if (kind == 3) begin
			if (rand_below(3) == 0) begin
				p.rs2_value = p.rs1_value;
			end else if (rand_below(2) == 0) begin
				p.rs2_value[31] = ~p.rs1_value[31]; // signs differ
			end
			p.cond_branch   = (rand_below(2) == 0);
			p.uncond_branch = (rand_below(4) == 0);
			p.opa_sel       = rv32_isa_pkg::opa_pc;
			p.opb_sel       = p.uncond_branch ? rv32_isa_pkg::opb_j_imm : rv32_isa_pkg::opb_b_imm;
			p.alu_func      = rv32_isa_pkg::alu_add;
		end
		return p;
	endfunction

	function automatic logic [31:0] sign_extend(input logic [31:0] field, input int bits);
		logic signed [31:0] t;
		t = field << (32 - bits);
		return t >>> (32 - bits);
	endfunction

	// reference model of one packet
	function automatic exec_unit_pkg::result_packet_t expected_result(
		input exec_unit_pkg::issue_packet_t p);
		exec_unit_pkg::result_packet_t r;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  sh;
		logic [63:0] prod;
		longint      sa;
		longint      sb;
		logic        cond;
		case (p.opa_sel)
			rv32_isa_pkg::opa_rs1: a = p.rs1_value;
			rv32_isa_pkg::opa_npc: a = p.npc;
			rv32_isa_pkg::opa_pc:  a = p.pc;
			default:               a = 32'h0;
		endcase
		case (p.opb_sel)
			rv32_isa_pkg::opb_i_imm: b = sign_extend(32'(p.inst[31:20]), 12);
			rv32_isa_pkg::opb_s_imm: b = sign_extend(32'({p.inst[31:25], p.inst[11:7]}), 12);
			rv32_isa_pkg::opb_b_imm: b = sign_extend(32'({p.inst[31], p.inst[7], p.inst[30:25],
				p.inst[11:8], 1'b0}), 13);
			rv32_isa_pkg::opb_u_imm: b = {p.inst[31:12], 12'h000};
			rv32_isa_pkg::opb_j_imm: b = sign_extend(32'({p.inst[31], p.inst[19:12], p.inst[20],
				p.inst[30:21], 1'b0}), 21);
			default:                 b = p.rs2_value;
		endcase
		sh = b[4:0];
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		prod = sa * sb;
		case (p.alu_func)
			rv32_isa_pkg::alu_add:  r.value = a + b;
			rv32_isa_pkg::alu_sub:  r.value = a - b;
			rv32_isa_pkg::alu_and:  r.value = a & b;
			rv32_isa_pkg::alu_or:   r.value = a | b;
			rv32_isa_pkg::alu_xor:  r.value = a ^ b;
			rv32_isa_pkg::alu_slt:  r.value = (sa < sb) ? 32'd1 : 32'd0;
			rv32_isa_pkg::alu_sltu: r.value = (a < b) ? 32'd1 : 32'd0;
			rv32_isa_pkg::alu_sll:  r.value = a << sh;
			rv32_isa_pkg::alu_srl:  r.value = a >> sh;
			rv32_isa_pkg::alu_sra:  r.value = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
			rv32_isa_pkg::alu_mul:  r.value = prod[31:0];
			rv32_isa_pkg::alu_mulh: r.value = prod[63:32];
			rv32_isa_pkg::alu_mulhsu: begin
				prod = sa * longint'({32'h0, b});
				r.value = prod[63:32];
			end
			default: begin // mulhu
				prod = {32'h0, a} * {32'h0, b};
				r.value = prod[63:32];
			end
		endcase
		case (p.inst[14:12])
			3'b000:  cond = (p.rs1_value == p.rs2_value);
			3'b001:  cond = (p.rs1_value != p.rs2_value);
			3'b100:  cond = ($signed(p.rs1_value) < $signed(p.rs2_value));
			3'b101:  cond = ($signed(p.rs1_value) >= $signed(p.rs2_value));
			3'b110:  cond = (p.rs1_value < p.rs2_value);
			3'b111:  cond = (p.rs1_value >= p.rs2_value);
			default: cond = 1'b0;
		endcase
		r.take_branch = p.uncond_branch | (p.cond_branch & cond);
		r.dest_tag    = p.dest_tag;
		return r;
	endfunction

	initial begin : stimulus
		int gap;
		int burst;
		int offered;
		int kind;
		seed = 96;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		issue_kind = 0;
		result_ready = 1'b0;
		gap = 0;
		burst = 0;
		offered = 0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("reset result_valid", 32'd0, 32'(result_valid));
		check_value("reset issue_ready", 32'd1, 32'(issue_ready));
		while (received < num_packets) begin
			@(posedge clock);
			if (burst > 0) begin // long stall on the result side
				result_ready <= 1'b0;
				burst = burst - 1;
			end else if (rand_below(50) == 0) begin
				result_ready <= 1'b0;
				burst = 20 + int'(rand_below(30));
			end else begin
				result_ready <= (rand_below(100) < 60);
			end
			// next packet only once the current one is taken
			if (!issue_valid || issue_fire) begin
				if (offered < num_packets && gap == 0) begin
					kind = int'(rand_below(4));
					issue <= random_packet(kind);
					issue_kind <= kind;
					issue_valid <= 1'b1;
					offered = offered + 1;
					gap = (rand_below(3) == 0) ? int'(rand_below(5)) + 1 : 0;
				end else begin
					issue_valid <= 1'b0;
					if (gap > 0) begin
						gap = gap - 1;
					end
				end
			end
		end
		result_ready <= 1'b1;
		repeat (10) @(posedge clock);
		if (max_in_flight < queue_depth + 1) begin
			fail_run("back-pressure never filled the issue latch and the queue");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	// sampled mid-cycle, where inputs and outputs are settled
	always @(negedge clock) begin : monitor
		if (reset) begin
			issue_fire = 1'b0;
		end else begin
			in_flight = issued - received;
			if (in_flight > max_in_flight) begin
				max_in_flight = in_flight;
			end
			// latch and queue both full, so only a leaving head frees a slot
			check_value("issue_ready", 32'((in_flight <= queue_depth) || result_ready),
				32'(issue_ready));
			if (result_valid && result_ready) begin
				if (expected.size() == 0) begin
					fail_run("result transfer with no packet outstanding");
				end else begin
					want = expected.pop_front();
					name = expected_names.pop_front();
					check_value({name, " dest_tag"}, 32'(want.dest_tag), 32'(result.dest_tag));
					check_value({name, " value"}, want.value, result.value);
					check_value({name, " take_branch"}, 32'(want.take_branch),
						32'(result.take_branch));
					received = received + 1;
				end
			end
			issue_fire = issue_valid && issue_ready;
			if (issue_fire) begin
				expected.push_back(expected_result(issue));
				expected_names.push_back($sformatf("%s packet %0d", kind_name(issue_kind), issued));
				issued = issued + 1;
			end
		end
	end

	always @(posedge clock) begin : watchdog
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			fail_run("timeout before all results came back");
		end
	end

endmodule

// File: hdl/int_exec_unit.sv
`timescale 1ns/1ps

module int_exec_unit #(
	parameter int queue_depth = 4
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           issue_valid,
	input  exec_unit_pkg::issue_packet_t   issue,
	input  logic                           result_ready,
	output logic                           issue_ready,
	output logic                           result_valid,
	output exec_unit_pkg::result_packet_t  result
);

	logic                          held_valid;
	exec_unit_pkg::issue_packet_t  held;
	logic                          advance;     // queue accepts the held result
	rv32_isa_pkg::word_t           operand_a;
	rv32_isa_pkg::word_t           operand_b;
	rv32_isa_pkg::word_t           alu_value;
	logic                          take_branch;
	exec_unit_pkg::result_packet_t push_packet;

	issue_latch u_issue_latch (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.advance     (advance),
		.issue_ready (issue_ready),
		.held_valid  (held_valid),
		.held        (held)
	);

	operand_select u_operand_select (
		.held      (held),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	int_alu u_int_alu (
		.operand_a (operand_a),
		.operand_b (operand_b),
		.func      (held.alu_func),
		.value     (alu_value)
	);

	branch_resolve u_branch_resolve (
		.rs1_value     (held.rs1_value),
		.rs2_value     (held.rs2_value),
		.funct3        (held.inst[14:12]),
		.cond_branch   (held.cond_branch),
		.uncond_branch (held.uncond_branch),
		.take_branch   (take_branch)
	);

	assign push_packet = '{dest_tag: held.dest_tag, value: alu_value,
		take_branch: take_branch};

	completion_queue #(
		.queue_depth (queue_depth)
	) u_completion_queue (
		.clock        (clock),
		.reset        (reset),
		.push_valid   (held_valid),
		.push         (push_packet),
		.result_ready (result_ready),
		.push_ready   (advance),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

// File: hdl/completion_queue.sv
`timescale 1ns/1ps

module completion_queue #(
	parameter int queue_depth = 4 // power of two, at least 2
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           push_valid,
	input  exec_unit_pkg::result_packet_t  push,
	input  logic                           result_ready,
	output logic                           push_ready,
	output logic                           result_valid,
	output exec_unit_pkg::result_packet_t  result
);

	localparam int ptr_w = $clog2(queue_depth);

	typedef logic [ptr_w-1:0] ptr_t; // wraps on its own
	typedef logic [ptr_w:0] count_t; // 0 .. queue_depth

	exec_unit_pkg::result_packet_t mem [queue_depth];

	ptr_t   wr_ptr;
	ptr_t   rd_ptr;
	count_t count;
	logic   full;
	logic   do_push;
	logic   do_pop;

	assign full         = (count == count_t'(queue_depth));
	assign result_valid = (count != '0);
	assign result       = mem[rd_ptr]; // show-ahead head entry

	// a pop frees the slot in the same cycle
	assign push_ready = !full || result_ready;
	assign do_push    = push_valid && push_ready;
	assign do_pop     = result_valid && result_ready;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

// File: hdl/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
	input  rv32_isa_pkg::word_t   rs1_value,
	input  rv32_isa_pkg::word_t   rs2_value,
	input  rv32_isa_pkg::funct3_t funct3,
	input  logic                  cond_branch,
	input  logic                  uncond_branch,
	output logic                  take_branch
);

	logic is_eq;
	logic is_lt;  // signed
	logic is_ltu; // unsigned
	logic cond;

	assign is_eq  = (rs1_value == rs2_value);
	assign is_lt  = ($signed(rs1_value) < $signed(rs2_value));
	assign is_ltu = (rs1_value < rs2_value);

	always_comb begin
		case (funct3)
			3'b000:  cond = is_eq;   // beq
			3'b001:  cond = !is_eq;  // bne
			3'b100:  cond = is_lt;   // blt
			3'b101:  cond = !is_lt;  // bge
			3'b110:  cond = is_ltu;  // bltu
			3'b111:  cond = !is_ltu; // bgeu
			default: cond = 1'b0;    // 010 and 011 are not branches
		endcase
	end

	// jumps always redirect, branches only on a true condition
	assign take_branch = uncond_branch || (cond_branch && cond);

endmodule

// File: hdl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
	input  rv32_isa_pkg::word_t     operand_a,
	input  rv32_isa_pkg::word_t     operand_b,
	input  rv32_isa_pkg::alu_func_e func,
	output rv32_isa_pkg::word_t     value
);

	localparam int w = rv32_isa_pkg::xlen;
	localparam rv32_isa_pkg::word_t bad_func = 32'hbad0_a1a1;

	typedef logic [2*w-1:0] dword_t; // full product width
	typedef logic [4:0] shamt_t;

	dword_t a_sext;
	dword_t b_sext;
	dword_t a_zext;
	dword_t b_zext;
	dword_t prod_ss;
	dword_t prod_su;
	dword_t prod_uu;
	shamt_t shamt;

	// extended to 64 bits so the low 64 bits of each product are exact
	assign a_sext = {{w{operand_a[w-1]}}, operand_a};
	assign b_sext = {{w{operand_b[w-1]}}, operand_b};
	assign a_zext = {{w{1'b0}}, operand_a};
	assign b_zext = {{w{1'b0}}, operand_b};

	assign prod_ss = a_sext * b_sext;
	assign prod_su = a_sext * b_zext;
	assign prod_uu = a_zext * b_zext;

	assign shamt = operand_b[4:0]; // upper bits ignored

	always_comb begin
		case (func)
			rv32_isa_pkg::alu_add:    value = operand_a + operand_b;
			rv32_isa_pkg::alu_sub:    value = operand_a - operand_b;
			rv32_isa_pkg::alu_and:    value = operand_a & operand_b;
			rv32_isa_pkg::alu_or:     value = operand_a | operand_b;
			rv32_isa_pkg::alu_xor:    value = operand_a ^ operand_b;
			rv32_isa_pkg::alu_slt:    value = w'($signed(operand_a) < $signed(operand_b));
			rv32_isa_pkg::alu_sltu:   value = w'(operand_a < operand_b);
			rv32_isa_pkg::alu_sll:    value = operand_a << shamt;
			rv32_isa_pkg::alu_srl:    value = operand_a >> shamt;
			rv32_isa_pkg::alu_sra:    value = $signed(operand_a) >>> shamt;
			rv32_isa_pkg::alu_mul:    value = prod_ss[w-1:0];
			rv32_isa_pkg::alu_mulh:   value = prod_ss[2*w-1:w];
			rv32_isa_pkg::alu_mulhsu: value = prod_su[2*w-1:w];
			rv32_isa_pkg::alu_mulhu:  value = prod_uu[2*w-1:w];
			default:                  value = bad_func; // codes e and f
		endcase
	end

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/1ps

module operand_select (
	input  exec_unit_pkg::issue_packet_t held,
	output rv32_isa_pkg::word_t          operand_a,
	output rv32_isa_pkg::word_t          operand_b
);

	localparam rv32_isa_pkg::word_t bad_opb = 32'hbad0_0b0b; // shows up on a bad select
	localparam int sext_w = rv32_isa_pkg::xlen - 12;

	rv32_isa_pkg::inst_t inst;
	rv32_isa_pkg::word_t i_imm;
	rv32_isa_pkg::word_t s_imm;
	rv32_isa_pkg::word_t b_imm;
	rv32_isa_pkg::word_t u_imm;
	rv32_isa_pkg::word_t j_imm;

	assign inst = held.inst;

	// immediate decoders with the sign bit always at inst[31]
	assign i_imm = {{sext_w{inst[31]}}, inst[31:20]};
	assign s_imm = {{sext_w{inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{(sext_w - 1){inst[31]}}, inst[31], inst[7], inst[30:25],
		inst[11:8], 1'b0};
	assign u_imm = {inst[31:12], 12'b0};
	assign j_imm = {{(sext_w - 9){inst[31]}}, inst[31], inst[19:12], inst[20],
		inst[30:21], 1'b0}; // 21-bit jump offset

	always_comb begin
		case (held.opa_sel)
			rv32_isa_pkg::opa_rs1: operand_a = held.rs1_value;
			rv32_isa_pkg::opa_npc: operand_a = held.npc;
			rv32_isa_pkg::opa_pc:  operand_a = held.pc;
			default:               operand_a = '0; // opa_zero
		endcase
	end

	always_comb begin
		case (held.opb_sel)
			rv32_isa_pkg::opb_rs2:   operand_b = held.rs2_value;
			rv32_isa_pkg::opb_i_imm: operand_b = i_imm;
			rv32_isa_pkg::opb_s_imm: operand_b = s_imm;
			rv32_isa_pkg::opb_b_imm: operand_b = b_imm;
			rv32_isa_pkg::opb_u_imm: operand_b = u_imm;
			rv32_isa_pkg::opb_j_imm: operand_b = j_imm;
			default:                 operand_b = bad_opb; // codes 6 and 7
		endcase
	end

endmodule

// File: hdl/issue_latch.sv
`timescale 1ns/1ps

module issue_latch (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          issue_valid,
	input  exec_unit_pkg::issue_packet_t  issue,
	input  logic                          advance,     // downstream takes held this cycle
	output logic                          issue_ready,
	output logic                          held_valid,
	output exec_unit_pkg::issue_packet_t  held
);

	logic drain;
	logic load;

	// content leaves when valid and the queue accepts it
	assign drain = held_valid && advance;

	// room when empty, or when the current entry is leaving
	assign issue_ready = !held_valid || drain;
	assign load = issue_valid && issue_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (issue_ready) begin
			held_valid <= issue_valid; // refill or go empty
		end
	end

	// packet payload
	always_ff @(posedge clock) begin
		if (load) begin
			held <= issue;
		end
	end

endmodule

// File: hdl/exec_unit_pkg.sv
package exec_unit_pkg;

	typedef logic [5:0] tag_t; // physical destination register tag

	// packet handed over by the reservation station
	typedef struct packed {
		rv32_isa_pkg::word_t     pc;
		rv32_isa_pkg::word_t     npc;
		rv32_isa_pkg::inst_t     inst;          // immediates and funct3 come from here
		rv32_isa_pkg::word_t     rs1_value;
		rv32_isa_pkg::word_t     rs2_value;
		rv32_isa_pkg::opa_sel_e  opa_sel;
		rv32_isa_pkg::opb_sel_e  opb_sel;
		rv32_isa_pkg::alu_func_e alu_func;
		logic                    cond_branch;   // bxx instruction
		logic                    uncond_branch; // jal / jalr
		tag_t                    dest_tag;
	} issue_packet_t;

	// packet sent toward the common data bus
	typedef struct packed {
		tag_t                dest_tag;
		rv32_isa_pkg::word_t value;
		logic                take_branch;
	} result_packet_t;

endpackage

// File: hdl/rv32_isa_pkg.sv
package rv32_isa_pkg;

	// RV32 data width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t; // operands, results, pc values
	typedef logic [31:0] inst_t;     // raw instruction word
	typedef logic [2:0] funct3_t;    // inst[14:12], the branch condition code

	// ALU function codes
	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_and    = 4'h2,
		alu_or     = 4'h3,
		alu_xor    = 4'h4,
		alu_slt    = 4'h5,
		alu_sltu   = 4'h6,
		alu_sll    = 4'h7,
		alu_srl    = 4'h8,
		alu_sra    = 4'h9,
		alu_mul    = 4'ha,
		alu_mulh   = 4'hb,
		alu_mulhsu = 4'hc,
		alu_mulhu  = 4'hd
	} alu_func_e;

	// operand A source
	typedef enum logic [1:0] {
		opa_rs1  = 2'd0,
		opa_npc  = 2'd1,
		opa_pc   = 2'd2,
		opa_zero = 2'd3
	} opa_sel_e;

	// operand B source with codes 6 and 7 unused
	typedef enum logic [2:0] {
		opb_rs2   = 3'd0,
		opb_i_imm = 3'd1,
		opb_s_imm = 3'd2,
		opb_b_imm = 3'd3,
		opb_u_imm = 3'd4,
		opb_j_imm = 3'd5
	} opb_sel_e;

endpackage
